// File: core_pkg.sv
`default_nettype none

package core_pkg;

    // ========================================
    // Basic types
    // ========================================

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_view_t;

    // Store layout, the rd field carries the low offset bits.
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    typedef union packed {
        r_view_t r_view;
        s_view_t s_view;
    } instr_t;

    // ========================================
    // Encodings
    // ========================================

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_sel_e;

    // ========================================
    // Memory sizes and reset values
    // ========================================

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam xlen_t RESET_PC  = 32'h0000_0000;
    localparam xlen_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  core_pkg::xlen_t     f_pc,
    input  core_pkg::xlen_t     f_instr,
    input  logic                redirect,
    input  logic                e_valid,
    input  core_pkg::reg_idx_t  e_rd,
    input  logic                e_mem_read,
    input  logic                wb_we,
    input  core_pkg::reg_idx_t  wb_rd,
    input  core_pkg::xlen_t     wb_data,
    output logic                stall,
    output logic                d_valid,
    output core_pkg::xlen_t     d_pc,
    output core_pkg::reg_idx_t  d_rs1,
    output core_pkg::reg_idx_t  d_rs2,
    output core_pkg::xlen_t     d_rs1_val,
    output core_pkg::xlen_t     d_rs2_val,
    output core_pkg::xlen_t     d_imm,
    output core_pkg::reg_idx_t  d_rd,
    output core_pkg::alu_op_e   d_alu_op,
    output logic                d_use_imm,
    output logic                d_op1_pc,
    output logic                d_is_branch,
    output logic                d_is_jal,
    output logic                d_is_jalr,
    output logic [2:0]          d_funct3,
    output logic                d_mem_read,
    output logic                d_mem_write,
    output logic                d_reg_write,
    output core_pkg::wb_sel_e   d_wb_sel
);
    import core_pkg::*;

    instr_t   ins;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    regs [1:31];
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    imm_i;
    xlen_t    imm_s;
    xlen_t    imm_b;
    xlen_t    imm_u;
    xlen_t    imm_j;
    xlen_t    imm;
    alu_op_e  alu_op;
    wb_sel_e  wb_sel;
    logic     use_rs1;
    logic     use_rs2;
    logic     use_imm;
    logic     op1_pc;
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     bubble;

    function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign ins = f_instr;
    assign rs1 = ins.r_view.rs1;
    assign rs2 = ins.r_view.rs2;

    assign imm_i = {{20{f_instr[31]}}, f_instr[31:20]};
    assign imm_s = {{20{ins.s_view.imm_hi[6]}}, ins.s_view.imm_hi, ins.s_view.imm_lo};
    assign imm_b = {{19{f_instr[31]}}, f_instr[31], f_instr[7], f_instr[30:25],
                    f_instr[11:8], 1'b0};
    assign imm_u = {f_instr[31:12], 12'b0};
    assign imm_j = {{11{f_instr[31]}}, f_instr[31], f_instr[19:12], f_instr[20],
                    f_instr[30:21], 1'b0};

    // ========================================
    // Control decode
    // ========================================

    always_comb begin
        imm       = imm_i;
        alu_op    = ALU_ADD;
        wb_sel    = WB_ALU;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        use_imm   = 1'b0;
        op1_pc    = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        case (opcode_e'(ins.r_view.opcode))
            OPC_OP: begin
                reg_write = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                alu_op    = alu_decode(ins.r_view.funct3, ins.r_view.funct7[5]);
            end
            OPC_OP_IMM: begin
                reg_write = 1'b1;
                use_rs1   = 1'b1;
                use_imm   = 1'b1;
                // Only SRAI takes the alternate bit, ADDI never means SUB.
                alu_op    = alu_decode(ins.r_view.funct3,
                                       ins.r_view.funct3 == 3'b101 && ins.r_view.funct7[5]);
            end
            OPC_LOAD: begin
                reg_write = 1'b1;
                use_rs1   = 1'b1;
                use_imm   = 1'b1;
                mem_read  = 1'b1;
                wb_sel    = WB_MEM;
            end
            OPC_STORE: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                use_imm   = 1'b1;
                mem_write = 1'b1;
                imm       = imm_s;
            end
            OPC_BRANCH: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                is_branch = 1'b1;
                imm       = imm_b;
            end
            OPC_JAL: begin
                reg_write = 1'b1;
                is_jal    = 1'b1;
                wb_sel    = WB_LINK;
                imm       = imm_j;
            end
            OPC_JALR: begin
                reg_write = 1'b1;
                use_rs1   = 1'b1;
                use_imm   = 1'b1;
                is_jalr   = 1'b1;
                wb_sel    = WB_LINK;
            end
            OPC_LUI: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = ALU_PASS_B;
                imm       = imm_u;
            end
            OPC_AUIPC: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                op1_pc    = 1'b1;
                imm       = imm_u;
            end
            default: ;
        endcase
    end

    // Load still in the result stage feeding this instruction.
    assign stall = e_valid && e_mem_read && (e_rd != '0) &&
                   ((use_rs1 && rs1 == e_rd) || (use_rs2 && rs2 == e_rd));
    assign bubble = stall || redirect;

    // ========================================
    // Register file
    // ========================================

    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_val = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            d_valid     <= 1'b0;
            d_is_branch <= 1'b0;
            d_is_jal    <= 1'b0;
            d_is_jalr   <= 1'b0;
            d_mem_read  <= 1'b0;
            d_mem_write <= 1'b0;
            d_reg_write <= 1'b0;
        end else begin
            d_valid     <= !bubble;
            d_is_branch <= is_branch && !bubble;
            d_is_jal    <= is_jal && !bubble;
            d_is_jalr   <= is_jalr && !bubble;
            d_mem_read  <= mem_read && !bubble;
            d_mem_write <= mem_write && !bubble;
            d_reg_write <= reg_write && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        d_pc      <= f_pc;
        d_rs1     <= rs1;
        d_rs2     <= rs2;
        d_rs1_val <= rs1_val;
        d_rs2_val <= rs2_val;
        d_imm     <= imm;
        d_rd      <= ins.r_view.rd;
        d_alu_op  <= alu_op;
        d_use_imm <= use_imm;
        d_op1_pc  <= op1_pc;
        d_funct3  <= ins.r_view.funct3;
        d_wb_sel  <= wb_sel;
    end

    a_bubble_after_kill : assert property (
        @(posedge clk) disable iff (!arst_n) (stall || redirect) |=> !d_valid
    );

    a_x0_never_written : assert property (
        @(posedge clk) disable iff (!arst_n) wb_we |-> (wb_rd != '0)
    );

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                d_valid,
    input  core_pkg::xlen_t     d_pc,
    input  core_pkg::reg_idx_t  d_rs1,
    input  core_pkg::reg_idx_t  d_rs2,
    input  core_pkg::xlen_t     d_rs1_val,
    input  core_pkg::xlen_t     d_rs2_val,
    input  core_pkg::xlen_t     d_imm,
    input  core_pkg::reg_idx_t  d_rd,
    input  core_pkg::alu_op_e   d_alu_op,
    input  logic                d_use_imm,
    input  logic                d_op1_pc,
    input  logic                d_is_branch,
    input  logic                d_is_jal,
    input  logic                d_is_jalr,
    input  logic [2:0]          d_funct3,
    input  logic                d_mem_read,
    input  logic                d_mem_write,
    input  logic                d_reg_write,
    input  core_pkg::wb_sel_e   d_wb_sel,
    input  logic                wb_we,
    input  core_pkg::reg_idx_t  wb_rd,
    input  core_pkg::xlen_t     wb_data,
    output logic                redirect,
    output core_pkg::xlen_t     redirect_pc,
    output logic                e_valid,
    output core_pkg::xlen_t     e_pc,
    output core_pkg::reg_idx_t  e_rd,
    output core_pkg::xlen_t     e_alu_res,
    output core_pkg::xlen_t     e_store_data,
    output logic                e_mem_read,
    output logic                e_mem_write,
    output logic                e_reg_write,
    output core_pkg::wb_sel_e   e_wb_sel
);
    import core_pkg::*;

    xlen_t rs1_fwd;
    xlen_t rs2_fwd;
    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_res;
    xlen_t link;
    logic  taken;

    // Younger result first, load data only arrives through wb_data.
    function automatic xlen_t forward(input reg_idx_t rs, input xlen_t rf_val);
        if (rs == '0) return '0;
        if (e_valid && e_reg_write && !e_mem_read && e_rd == rs) return e_alu_res;
        if (wb_we && wb_rd == rs) return wb_data;
        return rf_val;
    endfunction

    always_comb begin
        rs1_fwd = forward(d_rs1, d_rs1_val);
        rs2_fwd = forward(d_rs2, d_rs2_val);
    end

    assign op_a = d_op1_pc ? d_pc : rs1_fwd;
    assign op_b = d_use_imm ? d_imm : rs2_fwd;

    // ========================================
    // ALU and branch compare
    // ========================================

    always_comb begin
        case (d_alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_b;
        endcase
    end

    always_comb begin
        case (d_funct3)
            3'b000:  taken = rs1_fwd == rs2_fwd;
            3'b001:  taken = rs1_fwd != rs2_fwd;
            3'b100:  taken = $signed(rs1_fwd) < $signed(rs2_fwd);
            3'b101:  taken = $signed(rs1_fwd) >= $signed(rs2_fwd);
            3'b110:  taken = rs1_fwd < rs2_fwd;
            3'b111:  taken = rs1_fwd >= rs2_fwd;
            default: taken = 1'b0;
        endcase
    end

    // Control bits are already cleared for bubbles by decode.
    assign redirect    = d_is_jal || d_is_jalr || (d_is_branch && taken);
    assign redirect_pc = d_is_jalr ? {alu_res[31:1], 1'b0} : d_pc + d_imm;
    assign link        = d_pc + 32'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_valid     <= 1'b0;
            e_mem_read  <= 1'b0;
            e_mem_write <= 1'b0;
            e_reg_write <= 1'b0;
        end else begin
            e_valid     <= d_valid;
            e_mem_read  <= d_mem_read;
            e_mem_write <= d_mem_write;
            e_reg_write <= d_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        e_pc         <= d_pc;
        e_rd         <= d_rd;
        e_alu_res    <= (d_wb_sel == WB_LINK) ? link : alu_res;
        e_store_data <= rs2_fwd;
        e_wb_sel     <= d_wb_sel;
    end

    a_redirect_from_valid : assert property (
        @(posedge clk) disable iff (!arst_n) redirect |-> d_valid
    );

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            imem_we,
    input  core_pkg::xlen_t imem_addr,
    input  core_pkg::xlen_t imem_wdata,
    input  logic            run,
    input  logic            stall,
    input  logic            redirect,
    input  core_pkg::xlen_t redirect_pc,
    output core_pkg::xlen_t f_pc,
    output core_pkg::xlen_t f_instr
);
    import core_pkg::*;

    xlen_t imem [IMEM_WORDS];
    xlen_t pc;

    // Load port, used only while the core is halted.
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr[IMEM_AW+1:2]] <= imem_wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= RESET_PC;
            f_pc    <= RESET_PC;
            f_instr <= NOP_INSTR;
        end else if (!run) begin
            pc      <= RESET_PC;
            f_pc    <= RESET_PC;
            f_instr <= NOP_INSTR;
        end else if (redirect) begin
            // Word in flight belongs to the wrong path.
            pc      <= redirect_pc;
            f_pc    <= redirect_pc;
            f_instr <= NOP_INSTR;
        end else if (!stall) begin
            pc      <= pc + 32'd4;
            f_pc    <= pc;
            f_instr <= imem[pc[IMEM_AW+1:2]];
        end
    end

    a_load_while_halted : assert property (
        @(posedge clk) disable iff (!arst_n) !(imem_we && run)
    );

endmodule

`default_nettype wire

// File: filelist.f
core_pkg.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv

// File: result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                e_valid,
    input  core_pkg::xlen_t     e_pc,
    input  core_pkg::reg_idx_t  e_rd,
    input  core_pkg::xlen_t     e_alu_res,
    input  core_pkg::xlen_t     e_store_data,
    input  logic                e_mem_read,
    input  logic                e_mem_write,
    input  logic                e_reg_write,
    input  core_pkg::wb_sel_e   e_wb_sel,
    output logic                wb_we,
    output core_pkg::reg_idx_t  wb_rd,
    output core_pkg::xlen_t     wb_data,
    output logic                retire_valid,
    output core_pkg::xlen_t     retire_pc,
    output core_pkg::reg_idx_t  retire_rd,
    output core_pkg::xlen_t     retire_value
);
    import core_pkg::*;

    xlen_t dmem [DMEM_WORDS];
    xlen_t mem_rdata;
    logic [DMEM_AW-1:0] dmem_idx;

    // Word addressed, low address bits ignored.
    assign dmem_idx = e_alu_res[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (e_valid && e_mem_write) begin
            dmem[dmem_idx] <= e_store_data;
        end
    end

    assign mem_rdata = e_mem_read ? dmem[dmem_idx] : '0;

    // ========================================
    // Writeback
    // ========================================

    always_comb begin
        case (e_wb_sel)
            WB_MEM:  wb_data = mem_rdata;
            default: wb_data = e_alu_res;
        endcase
    end

    assign wb_we = e_valid && e_reg_write && (e_rd != '0);
    assign wb_rd = e_rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_we;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc    <= e_pc;
        retire_rd    <= e_rd;
        retire_value <= wb_data;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_rv_core --Mdir obj_dir -o tb_rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/tb_rv_core_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if echo "$output" | grep -F -q "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                imem_we,
    input  core_pkg::xlen_t     imem_addr,
    input  core_pkg::xlen_t     imem_wdata,
    input  logic                run,
    output logic                retire_valid,
    output core_pkg::xlen_t     retire_pc,
    output core_pkg::reg_idx_t  retire_rd,
    output core_pkg::xlen_t     retire_value
);
    import core_pkg::*;

    // Fetch and redirect.
    xlen_t    f_pc;
    xlen_t    f_instr;
    logic     stall;
    logic     redirect;
    xlen_t    redirect_pc;

    // ========================================
    // Decode to execute
    // ========================================
    logic     d_valid;
    xlen_t    d_pc;
    reg_idx_t d_rs1;
    reg_idx_t d_rs2;
    xlen_t    d_rs1_val;
    xlen_t    d_rs2_val;
    xlen_t    d_imm;
    reg_idx_t d_rd;
    alu_op_e  d_alu_op;
    logic     d_use_imm;
    logic     d_op1_pc;
    logic     d_is_branch;
    logic     d_is_jal;
    logic     d_is_jalr;
    logic [2:0] d_funct3;
    logic     d_mem_read;
    logic     d_mem_write;
    logic     d_reg_write;
    wb_sel_e  d_wb_sel;

    // ========================================
    // Execute to result and writeback
    // ========================================
    logic     e_valid;
    xlen_t    e_pc;
    reg_idx_t e_rd;
    xlen_t    e_alu_res;
    xlen_t    e_store_data;
    logic     e_mem_read;
    logic     e_mem_write;
    logic     e_reg_write;
    wb_sel_e  e_wb_sel;
    logic     wb_we;
    reg_idx_t wb_rd;
    xlen_t    wb_data;

    // Stage ports share their names with these nets.
    fetch_unit u_fetch (.*);

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    result_stage u_result (.*);

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);
    // 40 ns period.
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held for eight cycles, released just after an edge.
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #2 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import core_pkg::*;

    logic     clk;
    logic     arst_n;
    logic     imem_we;
    xlen_t    imem_addr;
    xlen_t    imem_wdata;
    logic     run;
    logic     retire_valid;
    xlen_t    retire_pc;
    reg_idx_t retire_rd;
    xlen_t    retire_value;

    xlen_t       prog [IMEM_WORDS];
    xlen_t       exp_pc [$];
    reg_idx_t    exp_rd [$];
    xlen_t       exp_val [$];
    logic [15:0] lfsr;

    tb_clock u_clock (.clk(clk), .arst_n(arst_n));

    rv_core DUT (.*);

    // ========================================
    // Encoders and random immediates
    // ========================================

    function automatic xlen_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic xlen_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic xlen_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic xlen_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic pick_imm12(output logic [11:0] imm);
        imm = '0;
        for (int b = 0; b < 12; b++) begin
            lfsr = lfsr_step(lfsr);
            imm  = {imm[10:0], lfsr[0]};
        end
    endtask

    task automatic place_instr(input xlen_t pc, input xlen_t word);
        prog[pc[IMEM_AW+1:2]] = word;
    endtask

    task automatic place_retiring(input xlen_t pc, input xlen_t word,
                                  input reg_idx_t rd, input xlen_t value);
        place_instr(pc, word);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_val.push_back(value);
    endtask

    // ========================================
    // Program and expected retirements
    // ========================================

    task automatic build_tables();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        xlen_t x1;
        xlen_t x2;
        xlen_t x3;
        xlen_t x4;
        xlen_t x6;
        lfsr = 16'd22;
        pick_imm12(imm_a);
        pick_imm12(imm_b);
        x1 = {{20{imm_a[11]}}, imm_a};
        x2 = {{20{imm_b[11]}}, imm_b};
        x3 = x1 + x2;
        x4 = x3 - x1;
        x6 = 32'h1234_5000;
        // Unused words hold ADDI x0, x0 with their own word index.
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i] = enc_i(i[11:0], 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
        end
        place_retiring(32'h00, enc_i(imm_a, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 5'd1, x1);
        place_retiring(32'h04, enc_i(imm_b, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), 5'd2, x2);
        place_retiring(32'h08, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), 5'd3, x3);
        place_retiring(32'h0C, enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4, OPC_OP), 5'd4, x4);
        place_retiring(32'h10, enc_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd5, OPC_OP), 5'd5, x4 ^ x3);
        place_retiring(32'h14, enc_u(20'h12345, 5'd6, OPC_LUI), 5'd6, x6);
        place_retiring(32'h18, enc_u(20'h00001, 5'd7, OPC_AUIPC), 5'd7, 32'h0000_1018);
        place_retiring(32'h1C, enc_i(12'h004, 5'd6, 3'b001, 5'd8, OPC_OP_IMM), 5'd8, x6 << 4);
        // Arithmetic shift of a negative word.
        place_retiring(32'h20, enc_i(12'h403, 5'd2, 3'b101, 5'd9, OPC_OP_IMM), 5'd9,
                       $signed(x2) >>> 3);
        place_retiring(32'h24, enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd10, OPC_OP), 5'd10,
                       ($signed(x1) < $signed(x2)) ? 32'd1 : 32'd0);
        place_retiring(32'h28, enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd11, OPC_OP), 5'd11,
                       (x1 < x2) ? 32'd1 : 32'd0);
        place_instr(32'h2C, enc_s(12'd8, 5'd3, 5'd0, 3'b010));
        place_retiring(32'h30, enc_i(12'd8, 5'd0, 3'b010, 5'd12, OPC_LOAD), 5'd12, x3);
        place_retiring(32'h34, enc_r(7'h00, 5'd12, 5'd12, 3'b000, 5'd13, OPC_OP), 5'd13,
                       x3 + x3);
        // Taken BEQ to 0x44 followed by a BNE that falls through.
        place_instr(32'h38, enc_b(13'd12, 5'd3, 5'd12, 3'b000));
        place_instr(32'h3C, enc_i(12'd1, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
        place_instr(32'h40, enc_i(12'd2, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
        place_instr(32'h44, enc_b(13'd8, 5'd1, 5'd1, 3'b001));
        place_retiring(32'h48, enc_i(12'd5, 5'd0, 3'b000, 5'd15, OPC_OP_IMM), 5'd15, 32'd5);
        place_retiring(32'h4C, enc_j(21'd12, 5'd16), 5'd16, 32'h50);
        place_instr(32'h50, enc_i(12'd3, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
        place_instr(32'h54, enc_i(12'd4, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
        place_retiring(32'h58, enc_i(12'h070, 5'd0, 3'b000, 5'd17, OPC_OP_IMM), 5'd17, 32'h70);
        // JALR to 0x71 lands on 0x70 once bit 0 is cleared.
        place_retiring(32'h5C, enc_i(12'd1, 5'd17, 3'b000, 5'd18, OPC_JALR), 5'd18, 32'h60);
        place_instr(32'h60, enc_i(12'd5, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
        place_instr(32'h64, enc_i(12'd6, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
        place_instr(32'h70, enc_i(12'd77, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
        place_retiring(32'h74, enc_r(7'h00, 5'd15, 5'd0, 3'b000, 5'd19, OPC_OP), 5'd19, 32'd5);
        // Park on a jump to itself. The word behind it must be killed every time.
        place_instr(32'h78, enc_j(21'd0, 5'd0));
        place_instr(32'h7C, enc_i(12'd7, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
    endtask

    // ========================================
    // Checks and waits
    // ========================================

    task automatic report_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR @ %0t: %s is %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR @ %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            $display("Reset was never released.");
            report_failure();
        end
    endtask

    task automatic wait_retire(input int idx);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 50) begin
            @(negedge clk);
            seen = retire_valid;
            cycles++;
        end
        if (!seen) begin
            $display("Timed out waiting for retirement %0d.", idx);
            report_failure();
        end
    endtask

    initial begin
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        run        = 1'b0;
        build_tables();
        wait_reset();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(posedge clk);
            #2;
            imem_we    = 1'b1;
            imem_addr  = i * 4;
            imem_wdata = prog[i];
        end
        @(posedge clk);
        #2 imem_we = 1'b0;
        @(posedge clk);
        #2 run = 1'b1;
        for (int i = 0; i < exp_pc.size(); i++) begin
            wait_retire(i);
            check_word(retire_pc, exp_pc[i], "retire_pc");
            check_reg(retire_rd, exp_rd[i], "retire_rd");
            check_word(retire_value, exp_val[i], "retire_value");
        end
        // Nothing else may retire once the program parks.
        for (int c = 0; c < 30; c++) begin
            @(negedge clk);
            if (retire_valid) begin
                $display("An extra instruction retired at pc %h.", retire_pc);
                report_failure();
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
